// ==== sources.f ====
source/rv_isa_pkg.sv
source/core_pkg.sv
source/decode_if.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_pc_unit.sv
source/rv_core_top.sv
verif/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - source/rv_isa_pkg.sv
  - source/core_pkg.sv
  - source/decode_if.sv
  - source/rv_decoder.sv
  - source/rv_regfile.sv
  - source/rv_alu.sv
  - source/rv_pc_unit.sv
  - source/rv_core_top.sv
  - target: test
    files:
      - verif/tb_rv_core.sv

// ==== verif/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core import rv_isa_pkg::*; ();

  localparam time CLK_PERIOD = 100;
  localparam int  MAX_ROWS   = 48;

  logic      clk;
  logic      rst;
  word_t     insn_from_imem;
  word_t     pc_to_imem;
  logic      halt;
  word_t     trace_completed_pc;
  word_t     trace_completed_insn;
  logic      trace_rd_we;
  reg_addr_t trace_rd;
  word_t     trace_rd_data;

  // stimulus table with one row per executed instruction
  string     row_name [MAX_ROWS];
  word_t     row_insn [MAX_ROWS];
  word_t     row_pc   [MAX_ROWS];
  logic      row_we   [MAX_ROWS];
  reg_addr_t row_rd   [MAX_ROWS];
  word_t     row_data [MAX_ROWS];
  logic      row_halt [MAX_ROWS];
  int        n_rows      = 0;
  logic      table_ready = 1'b0;
  int        errors      = 0;
  int        checks      = 0;

  rv_core_top UUT (
    .clk                  (clk),
    .rst                  (rst),
    .insn_from_imem       (insn_from_imem),
    .pc_to_imem           (pc_to_imem),
    .halt                 (halt),
    .trace_completed_pc   (trace_completed_pc),
    .trace_completed_insn (trace_completed_insn),
    .trace_rd_we          (trace_rd_we),
    .trace_rd             (trace_rd),
    .trace_rd_data        (trace_rd_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // instruction builders over the format views
  function automatic word_t r_type(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                   reg_addr_t rs1, reg_addr_t rs2);
    rv_insn_u w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = f3;
    w.r.rd     = rd;
    w.r.opcode = OPC_OP;
    return w;
  endfunction

  function automatic word_t i_type(opcode_e op, logic [2:0] f3, reg_addr_t rd,
                                   reg_addr_t rs1, word_t imm);
    rv_insn_u w;
    w.i.imm_11_0 = imm[11:0];
    w.i.rs1      = rs1;
    w.i.funct3   = f3;
    w.i.rd       = rd;
    w.i.opcode   = op;
    return w;
  endfunction

  function automatic word_t b_type(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
                                   word_t off);
    rv_insn_u w;
    w.b.imm_12   = off[12];
    w.b.imm_10_5 = off[10:5];
    w.b.rs2      = rs2;
    w.b.rs1      = rs1;
    w.b.funct3   = f3;
    w.b.imm_4_1  = off[4:1];
    w.b.imm_11   = off[11];
    w.b.opcode   = OPC_BRANCH;
    return w;
  endfunction

  function automatic word_t u_type(opcode_e op, reg_addr_t rd, logic [19:0] imm);
    rv_insn_u w;
    w.u.imm_31_12 = imm;
    w.u.rd        = rd;
    w.u.opcode    = op;
    return w;
  endfunction

  function automatic word_t j_type(reg_addr_t rd, word_t off);
    rv_insn_u w;
    w.j.imm_20    = off[20];
    w.j.imm_10_1  = off[10:1];
    w.j.imm_11    = off[11];
    w.j.imm_19_12 = off[19:12];
    w.j.rd        = rd;
    w.j.opcode    = OPC_JAL;
    return w;
  endfunction

  task automatic add_row(input string name, input word_t insn, input word_t pc,
                         input logic we, input reg_addr_t rd, input word_t data,
                         input logic hlt);
    row_name[n_rows] = name;
    row_insn[n_rows] = insn;
    row_pc[n_rows]   = pc;
    row_we[n_rows]   = we;
    row_rd[n_rows]   = rd;
    row_data[n_rows] = data;
    row_halt[n_rows] = hlt;
    n_rows++;
  endtask

  task automatic add_write_row(input string name, input word_t insn, input word_t pc,
                               input reg_addr_t rd, input word_t data);
    add_row(name, insn, pc, 1'b1, rd, data, 1'b0);
  endtask

  task automatic add_quiet_row(input string name, input word_t insn, input word_t pc,
                               input logic hlt);
    add_row(name, insn, pc, 1'b0, 5'd0, 32'h0, hlt);
  endtask

  // dynamic path of the program
  // x3 holds -5 and x4 holds 7 once built
  task automatic build_table();
    add_write_row("lui", u_type(OPC_LUI, 5'd1, 20'h80000), 32'h00, 5'd1, 32'h8000_0000);
    add_write_row("auipc", u_type(OPC_AUIPC, 5'd2, 20'h00001), 32'h04, 5'd2, 32'h0000_1004);
    add_write_row("addi_neg", i_type(OPC_OP_IMM, 3'b000, 5'd3, 5'd0, -5), 32'h08, 5'd3,
                  32'hFFFF_FFFB);
    add_write_row("addi_pos", i_type(OPC_OP_IMM, 3'b000, 5'd4, 5'd0, 7), 32'h0C, 5'd4, 32'h7);
    add_write_row("add", r_type(7'h00, 3'b000, 5'd5, 5'd3, 5'd4), 32'h10, 5'd5, 32'h2);
    add_write_row("sub", r_type(7'h20, 3'b000, 5'd6, 5'd4, 5'd3), 32'h14, 5'd6, 32'hC);
    add_write_row("and", r_type(7'h00, 3'b111, 5'd7, 5'd3, 5'd4), 32'h18, 5'd7, 32'h3);
    add_write_row("or", r_type(7'h00, 3'b110, 5'd8, 5'd3, 5'd4), 32'h1C, 5'd8, 32'hFFFF_FFFF);
    add_write_row("xor", r_type(7'h00, 3'b100, 5'd9, 5'd3, 5'd4), 32'h20, 5'd9, 32'hFFFF_FFFC);
    add_write_row("sll", r_type(7'h00, 3'b001, 5'd10, 5'd4, 5'd4), 32'h24, 5'd10, 32'h380);
    add_write_row("srl", r_type(7'h00, 3'b101, 5'd11, 5'd1, 5'd4), 32'h28, 5'd11, 32'h0100_0000);
    add_write_row("sra", r_type(7'h20, 3'b101, 5'd12, 5'd1, 5'd4), 32'h2C, 5'd12, 32'hFF00_0000);
    add_write_row("slt", r_type(7'h00, 3'b010, 5'd13, 5'd3, 5'd4), 32'h30, 5'd13, 32'h1);
    add_write_row("sltu", r_type(7'h00, 3'b011, 5'd14, 5'd3, 5'd4), 32'h34, 5'd14, 32'h0);
    add_write_row("slti", i_type(OPC_OP_IMM, 3'b010, 5'd15, 5'd3, -4), 32'h38, 5'd15, 32'h1);
    add_write_row("sltiu", i_type(OPC_OP_IMM, 3'b011, 5'd16, 5'd4, -1), 32'h3C, 5'd16, 32'h1);
    add_quiet_row("addi_x0", i_type(OPC_OP_IMM, 3'b000, 5'd0, 5'd4, 5), 32'h40, 1'b0);
    add_write_row("add_x0", r_type(7'h00, 3'b000, 5'd17, 5'd0, 5'd0), 32'h44, 5'd17, 32'h0);
    // each condition taken and then not taken
    add_quiet_row("beq_t", b_type(3'b000, 5'd4, 5'd4, 8), 32'h48, 1'b0);
    add_quiet_row("beq_n", b_type(3'b000, 5'd3, 5'd4, 8), 32'h50, 1'b0);
    add_quiet_row("bne_t", b_type(3'b001, 5'd3, 5'd4, 12), 32'h54, 1'b0);
    add_quiet_row("bne_n", b_type(3'b001, 5'd4, 5'd4, 8), 32'h60, 1'b0);
    add_quiet_row("blt_t", b_type(3'b100, 5'd3, 5'd4, 8), 32'h64, 1'b0);
    add_quiet_row("blt_n", b_type(3'b100, 5'd4, 5'd3, 8), 32'h6C, 1'b0);
    add_quiet_row("bge_t", b_type(3'b101, 5'd4, 5'd3, 8), 32'h70, 1'b0);
    add_quiet_row("bge_n", b_type(3'b101, 5'd3, 5'd4, 8), 32'h78, 1'b0);
    add_quiet_row("bltu_t", b_type(3'b110, 5'd4, 5'd3, 8), 32'h7C, 1'b0);
    add_quiet_row("bltu_n", b_type(3'b110, 5'd3, 5'd4, 8), 32'h84, 1'b0);
    // backward target
    add_quiet_row("bgeu_t", b_type(3'b111, 5'd3, 5'd4, -8), 32'h88, 1'b0);
    add_quiet_row("bgeu_n", b_type(3'b111, 5'd4, 5'd3, 8), 32'h80, 1'b0);
    add_write_row("jal", j_type(5'd18, 16), 32'h84, 5'd18, 32'h88);
    // x2 + 1 is odd so the target drops bit zero
    add_write_row("jalr", i_type(OPC_JALR, 3'b000, 5'd19, 5'd2, 1), 32'h94, 5'd19, 32'h98);
    add_quiet_row("ecall", i_type(OPC_SYSTEM, 3'b000, 5'd0, 5'd0, 0), 32'h1004, 1'b1);
    add_write_row("after_ecall", i_type(OPC_OP_IMM, 3'b000, 5'd20, 5'd19, 1), 32'h1008,
                  5'd20, 32'h99);
  endtask

  task automatic check(input string name, input string field, input word_t expected,
                       input word_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s %s: expected %h, actual %h", name, field, expected, actual);
    end
  endtask

  initial begin
    clk            = 1'b0;
    rst            = 1'b1;
    insn_from_imem = 32'h0000_0013;
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      insn_from_imem = row_insn[i];
      #(CLK_PERIOD / 4);
      check(row_name[i], "pc", row_pc[i], pc_to_imem);
      check(row_name[i], "completed_pc", row_pc[i], trace_completed_pc);
      check(row_name[i], "completed_insn", row_insn[i], trace_completed_insn);
      check(row_name[i], "rd_we", row_we[i], trace_rd_we);
      check(row_name[i], "halt", row_halt[i], halt);
      if (row_we[i]) begin
        check(row_name[i], "rd", row_rd[i], trace_rd);
        check(row_name[i], "rd_data", row_data[i], trace_rd_data);
      end
      @(negedge clk);
    end
    $display("%0d errors in %0d checks over %0d rows", errors, checks, n_rows);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog sized from the table length
  initial begin
    wait (table_ready);
    #((n_rows + 10) * CLK_PERIOD);
    $display("timeout: the test did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== source/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top import rv_isa_pkg::*, core_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  word_t     insn_from_imem,
  output word_t     pc_to_imem,
  output logic      halt,
  output word_t     trace_completed_pc,
  output word_t     trace_completed_insn,
  output logic      trace_rd_we,
  output reg_addr_t trace_rd,
  output word_t     trace_rd_data
);

  decode_if dec ();

  word_t rs1_data;
  word_t rs2_data;
  word_t alu_result;
  logic  branch_taken;

  rv_decoder u_decoder (
    .insn (insn_from_imem),
    .dec  (dec.decoder)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .dec        (dec.regfile),
    .rd_data    (alu_result),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .write_done (trace_rd_we)
  );

  rv_alu u_alu (
    .dec          (dec.alu),
    .pc           (pc_to_imem),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  rv_pc_unit u_pc_unit (
    .clk          (clk),
    .rst          (rst),
    .dec          (dec.pc_unit),
    .rs1_data     (rs1_data),
    .branch_taken (branch_taken),
    .pc           (pc_to_imem)
  );

  // ecall only reported outside reset
  assign halt = dec.halt && !rst;

  assign trace_completed_pc   = pc_to_imem;
  assign trace_completed_insn = insn_from_imem;
  assign trace_rd             = dec.rd;
  assign trace_rd_data        = alu_result;

endmodule

// ==== source/rv_pc_unit.sv ====
`timescale 1ns/1ps

module rv_pc_unit import rv_isa_pkg::*, core_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  decode_if.pc_unit dec,
  input  word_t     rs1_data,
  input  logic      branch_taken,
  output word_t     pc
);

  word_t pc_seq;
  word_t pc_rel;
  word_t pc_next;

  assign pc_seq = pc + PC_STEP;
  assign pc_rel = pc + dec.imm;

  always_comb begin
    case (dec.flow)
      FLOW_BRANCH: pc_next = branch_taken ? pc_rel : pc_seq;
      FLOW_JAL:    pc_next = pc_rel;
      // target lsb is always cleared
      FLOW_JALR:   pc_next = (rs1_data + dec.imm) & ~word_t'(1);
      default:     pc_next = pc_seq;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

// ==== source/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu import rv_isa_pkg::*, core_pkg::*; (
  decode_if.alu dec,
  input  word_t pc,
  input  word_t rs1_data,
  input  word_t rs2_data,
  output word_t result,
  output logic  branch_taken
);

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;

  always_comb begin
    case (dec.src_a)
      SRC_A_PC:   op_a = pc;
      SRC_A_ZERO: op_a = '0;
      default:    op_a = rs1_data;
    endcase
  end

  always_comb begin
    case (dec.src_b)
      SRC_B_IMM:  op_b = dec.imm;
      SRC_B_STEP: op_b = PC_STEP;
      default:    op_b = rs2_data;
    endcase
  end

  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      ALU_SUB:  result = op_a - op_b;
      ALU_SLL:  result = op_a << shamt;
      ALU_SLT:  result = word_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU: result = word_t'(op_a < op_b);
      ALU_XOR:  result = op_a ^ op_b;
      ALU_SRL:  result = op_a >> shamt;
      ALU_SRA:  result = $signed(op_a) >>> shamt;
      ALU_OR:   result = op_a | op_b;
      ALU_AND:  result = op_a & op_b;
      default:  result = op_a + op_b;
    endcase
  end

  // branch compare always on the two register operands
  always_comb begin
    case (dec.branch_cond)
      BR_EQ:   branch_taken = (rs1_data == rs2_data);
      BR_NE:   branch_taken = (rs1_data != rs2_data);
      BR_LT:   branch_taken = ($signed(rs1_data) < $signed(rs2_data));
      BR_GE:   branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
      BR_LTU:  branch_taken = (rs1_data < rs2_data);
      BR_GEU:  branch_taken = (rs1_data >= rs2_data);
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

// ==== source/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile import rv_isa_pkg::*, core_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  decode_if.regfile dec,
  input  word_t     rd_data,
  output word_t     rs1_data,
  output word_t     rs2_data,
  output logic      write_done
);

  word_t regs [NUM_REGS];

  // x0 is never written
  assign write_done = dec.wb_en && !rst && (dec.rd != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write_done) begin
      regs[dec.rd] <= rd_data;
    end
  end

  assign rs1_data = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
  assign rs2_data = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

endmodule

// ==== source/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder import rv_isa_pkg::*, core_pkg::*; (
  input word_t     insn,
  decode_if.decoder dec
);

  rv_insn_u   iw;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  logic [2:0] funct3;
  logic       is_reg;
  logic       f7_zero;
  logic       f7_alt;
  logic       alt_sel;
  logic       alu_ok;

  assign iw     = insn;
  assign funct3 = iw.r.funct3;

  assign imm_i = {{20{iw.i.imm_11_0[11]}}, iw.i.imm_11_0};
  assign imm_b = {{19{iw.b.imm_12}}, iw.b.imm_12, iw.b.imm_11, iw.b.imm_10_5,
                  iw.b.imm_4_1, 1'b0};
  assign imm_u = {iw.u.imm_31_12, 12'b0};
  assign imm_j = {{11{iw.j.imm_20}}, iw.j.imm_20, iw.j.imm_19_12, iw.j.imm_11,
                  iw.j.imm_10_1, 1'b0};

  // alu decode shared by OP and OP-IMM
  assign is_reg  = (iw.r.opcode == OPC_OP);
  assign f7_zero = (iw.r.funct7 == '0);
  assign f7_alt  = (iw.r.funct7 == FUNCT7_ALT);
  // immediate forms only have an alternate for SRAI
  assign alt_sel = f7_alt && ((funct3 == F3_SR) || (is_reg && funct3 == F3_ADD_SUB));

  always_comb begin
    if (is_reg) begin
      alu_ok = f7_zero || alt_sel;
    end else if (funct3 == F3_SLL) begin
      alu_ok = f7_zero;
    end else if (funct3 == F3_SR) begin
      alu_ok = f7_zero || f7_alt;
    end else begin
      alu_ok = 1'b1;
    end
  end

  assign dec.rs1 = iw.r.rs1;
  assign dec.rs2 = iw.r.rs2;
  assign dec.rd  = iw.r.rd;
  assign dec.branch_cond = branch_cond_e'(funct3);

  always_comb begin
    // defaults give a no-op that steps the PC
    dec.alu_op = ALU_ADD;
    dec.src_a  = SRC_A_RS1;
    dec.src_b  = SRC_B_IMM;
    dec.imm    = imm_i;
    dec.wb_en  = 1'b0;
    dec.flow   = FLOW_SEQ;
    dec.halt   = 1'b0;

    case (iw.r.opcode)
      OPC_LUI: begin
        dec.src_a = SRC_A_ZERO;
        dec.imm   = imm_u;
        dec.wb_en = 1'b1;
      end
      OPC_AUIPC: begin
        dec.src_a = SRC_A_PC;
        dec.imm   = imm_u;
        dec.wb_en = 1'b1;
      end
      OPC_JAL: begin
        dec.src_a = SRC_A_PC;
        dec.src_b = SRC_B_STEP;
        dec.imm   = imm_j;
        dec.wb_en = 1'b1;
        dec.flow  = FLOW_JAL;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          dec.src_a = SRC_A_PC;
          dec.src_b = SRC_B_STEP;
          dec.wb_en = 1'b1;
          dec.flow  = FLOW_JALR;
        end
      end
      OPC_BRANCH: begin
        // funct3 010 and 011 are not branches
        if (funct3[2:1] != 2'b01) begin
          dec.imm  = imm_b;
          dec.flow = FLOW_BRANCH;
        end
      end
      OPC_OP_IMM, OPC_OP: begin
        dec.alu_op = alu_op_e'({alt_sel, funct3});
        dec.src_b  = is_reg ? SRC_B_RS2 : SRC_B_IMM;
        dec.wb_en  = alu_ok;
      end
      OPC_SYSTEM: begin
        // only ECALL, all other fields zero
        dec.halt = (iw.i.imm_11_0 == '0) && (iw.i.rs1 == '0) &&
                   (funct3 == 3'b000) && (iw.i.rd == '0);
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== source/decode_if.sv ====
`timescale 1ns/1ps

interface decode_if import rv_isa_pkg::*, core_pkg::*; ();

  alu_op_e      alu_op;
  src_a_e       src_a;
  src_b_e       src_b;
  word_t        imm;
  reg_addr_t    rs1;
  reg_addr_t    rs2;
  reg_addr_t    rd;
  logic         wb_en;
  flow_e        flow;
  branch_cond_e branch_cond;
  logic         halt;

  modport decoder (
    output alu_op, src_a, src_b, imm, rs1, rs2, rd, wb_en, flow, branch_cond, halt
  );

  modport regfile (input rs1, rs2, rd, wb_en);

  modport alu (input alu_op, src_a, src_b, imm, branch_cond);

  modport pc_unit (input flow, imm);

endinterface

// ==== source/core_pkg.sv ====
package core_pkg;

  localparam int          NUM_REGS = 32;
  localparam logic [31:0] RESET_PC = 32'h0000_0000;
  localparam logic [31:0] PC_STEP  = 32'd4;

  // encoded as {alt, funct3} so the decoder can build it from the word
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  typedef enum logic [1:0] {
    SRC_A_RS1  = 2'd0,
    SRC_A_PC   = 2'd1,
    SRC_A_ZERO = 2'd2
  } src_a_e;

  typedef enum logic [1:0] {
    SRC_B_RS2  = 2'd0,
    SRC_B_IMM  = 2'd1,
    SRC_B_STEP = 2'd2
  } src_b_e;

  typedef enum logic [1:0] {
    FLOW_SEQ    = 2'd0,
    FLOW_BRANCH = 2'd1,
    FLOW_JAL    = 2'd2,
    FLOW_JALR   = 2'd3
  } flow_e;

  // values match the branch funct3 field
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_cond_e;

endpackage

// ==== source/rv_isa_pkg.sv ====
package rv_isa_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  // base opcodes handled by this core
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // selects SUB and SRA/SRAI
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  // funct3 codes that need a funct7 check
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SR      = 3'b101;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_e    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_addr_t   rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_addr_t  rd;
    opcode_e    opcode;
  } j_fmt_t;

  // one instruction word seen through every format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } rv_insn_u;

endpackage
